/* logic/sram_pkg.sv */
// shared bus data width, byte-lane count, RAM word union and slave state type
package sram_pkg;

        localparam int data_width = 32;                 // one bus and RAM word
        localparam int lane_count = data_width / 8;     // byte lanes per word

        // one RAM word, seen whole or lane by lane
        typedef union packed {
                logic [data_width-1:0]      word;
                logic [lane_count-1:0][7:0] lanes;
        } ram_word_t;

        // RAM slave controller phases
        typedef enum logic [1:0] {
                st_idle,                // waiting for cyc and stb
                st_read_wait,           // RAM read in flight
                st_merge_write,         // write back merged lanes
                st_ack                  // one-cycle ack to the master
        } slave_state_t;

endpackage

/* logic/wb_bus_if.sv */
// Wishbone classic bus bundle with master and slave modports
`timescale 1ns/100ps

interface wb_bus_if
        import sram_pkg::*;
#(
        parameter int addr_width = 10
) ();

        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [addr_width-1:0] adr;    // word address
        logic [lane_count-1:0] sel;
        logic [data_width-1:0] dat_w;
        logic [data_width-1:0] dat_r;
        logic                  ack;

        modport master (
                output cyc,
                output stb,
                output we,
                output adr,
                output sel,
                output dat_w,
                input  dat_r,
                input  ack
        );

        modport slave (
                input  cyc,
                input  stb,
                input  we,
                input  adr,
                input  sel,
                input  dat_w,
                output dat_r,
                output ack
        );

endinterface

/* logic/generic_spram.sv */
// behavioral single-port synchronous RAM with registered read
`timescale 1ns/100ps

module generic_spram
        import sram_pkg::*;
#(
        parameter int addr_width = 10
) (
        input  logic                  clk,
        input  logic                  re,
        input  logic                  we,
        input  logic [addr_width-1:0] addr,
        input  logic [data_width-1:0] data,
        output logic [data_width-1:0] q
);

        localparam int depth = 1 << addr_width;

        logic [data_width-1:0] mem [depth];

        // q holds its value until the next read
        always_ff @(posedge clk) begin
                if (re) begin
                        q <= mem[addr];
                end
        end

        always_ff @(posedge clk) begin
                if (we) begin
                        mem[addr] <= data;
                end
        end

        // read-during-write has no defined result on this port,
        // so the controller must never ask for both at one edge
        rw_exclusive: assert property (@(posedge clk) re |-> !we)
                else $error("generic_spram: read and write at the same edge, addr %0h", addr);

endmodule

/* logic/wb_arbiter.sv */
// round-robin arbiter for two Wishbone classic masters onto one shared bus
`timescale 1ns/100ps

module wb_arbiter
        import sram_pkg::*;
#(
        parameter int addr_width = 10
) (
        input  logic                  clk,
        input  logic                  rst_n,

        input  logic                  m0_cyc,
        input  logic                  m0_stb,
        input  logic                  m0_we,
        input  logic [addr_width-1:0] m0_adr,
        input  logic [lane_count-1:0] m0_sel,
        input  logic [data_width-1:0] m0_dat_w,
        output logic [data_width-1:0] m0_dat_r,
        output logic                  m0_ack,

        input  logic                  m1_cyc,
        input  logic                  m1_stb,
        input  logic                  m1_we,
        input  logic [addr_width-1:0] m1_adr,
        input  logic [lane_count-1:0] m1_sel,
        input  logic [data_width-1:0] m1_dat_w,
        output logic [data_width-1:0] m1_dat_r,
        output logic                  m1_ack,

        wb_bus_if.master              shared
);

        logic gnt_valid;        // some master was granted last cycle
        logic gnt_owner;        // 0 is m0, 1 is m1
        logic last_served;      // master that won the most recent choice
        logic owner_cyc;        // cyc of the registered owner
        logic hold;             // owner keeps the bus
        logic pick;             // round-robin choice when the bus is free
        logic cur_owner;        // owner seen by the bus this cycle

        assign owner_cyc = gnt_owner ? m1_cyc : m0_cyc;
        assign hold      = gnt_valid && owner_cyc;

        // on a tie the master not served last time wins
        assign pick      = (m0_cyc && m1_cyc) ? !last_served : m1_cyc;
        assign cur_owner = hold ? gnt_owner : pick;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        gnt_valid   <= 1'b0;
                        gnt_owner   <= 1'b0;
                        last_served <= 1'b1;    // m0 preferred first
                end else if (!hold) begin
                        gnt_valid <= m0_cyc || m1_cyc;
                        gnt_owner <= pick;
                        if (m0_cyc || m1_cyc) begin
                                last_served <= pick;
                        end
                end
        end

        // request routing, no added cycle
        assign shared.cyc   = cur_owner ? m1_cyc   : m0_cyc;
        assign shared.stb   = cur_owner ? m1_stb   : m0_stb;
        assign shared.we    = cur_owner ? m1_we    : m0_we;
        assign shared.adr   = cur_owner ? m1_adr   : m0_adr;
        assign shared.sel   = cur_owner ? m1_sel   : m0_sel;
        assign shared.dat_w = cur_owner ? m1_dat_w : m0_dat_w;

        // response goes to the owner only
        assign m0_ack   = shared.ack && !cur_owner;
        assign m1_ack   = shared.ack && cur_owner;
        assign m0_dat_r = cur_owner ? '0 : shared.dat_r;
        assign m1_dat_r = cur_owner ? shared.dat_r : '0;

        // ack returns only to the registered owner
        ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                (m0_ack || m1_ack) |->
                        (gnt_valid && (m0_ack != m1_ack) && (m1_ack == gnt_owner)))
                else $error("wb_arbiter: ack not given to the granted master alone");

        // an owner mid-cycle is never preempted
        grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
                (shared.cyc && !shared.ack) |=> $stable(cur_owner))
                else $error("wb_arbiter: grant moved while owner cyc was high");

endmodule

/* logic/wb_ram_slave.sv */
// Wishbone classic RAM slave with word reads, full writes and read-merge-write
`timescale 1ns/100ps

module wb_ram_slave
        import sram_pkg::*;
#(
        parameter int addr_width = 10
) (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic [data_width-1:0] q,
        wb_bus_if.slave               bus,
        output logic                  ram_re,
        output logic                  ram_we,
        output logic [addr_width-1:0] ram_addr,
        output logic [data_width-1:0] ram_data
);

        slave_state_t state;
        slave_state_t state_nxt;
        logic         req;              // new cycle seen while idle
        logic         full_word;        // all lanes selected
        ram_word_t    rd_word;
        ram_word_t    wr_word;
        ram_word_t    merged;

        assign req       = (state == st_idle) && bus.cyc && bus.stb;
        assign full_word = &bus.sel;

        always_comb begin
                state_nxt = state;
                case (state)
                        st_idle: begin
                                if (bus.cyc && bus.stb) begin
                                        if (bus.we && full_word) begin
                                                state_nxt = st_ack;     // written this edge
                                        end else begin
                                                state_nxt = st_read_wait;
                                        end
                                end
                        end
                        st_read_wait: begin
                                if (bus.we) begin
                                        state_nxt = st_merge_write;
                                end else begin
                                        state_nxt = st_ack;
                                end
                        end
                        st_merge_write: begin
                                state_nxt = st_ack;
                        end
                        st_ack: begin
                                state_nxt = st_idle;
                        end
                        default: begin
                                state_nxt = st_idle;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= st_idle;
                end else begin
                        state <= state_nxt;
                end
        end

        // lane merge of write data over the word read back
        assign rd_word = q;
        assign wr_word = bus.dat_w;

        always_comb begin
                merged = rd_word;
                for (int i = 0; i < lane_count; i++) begin
                        if (bus.sel[i]) begin
                                merged.lanes[i] = wr_word.lanes[i];
                        end
                end
        end

        // partial writes read first
        assign ram_re   = req && !(bus.we && full_word);
        assign ram_we   = (req && bus.we && full_word) || (state == st_merge_write);
        assign ram_addr = bus.adr;                      // held by the master
        assign ram_data = (state == st_merge_write) ? merged.word : bus.dat_w;

        assign bus.dat_r = q;                           // valid through the ack cycle
        assign bus.ack   = (state == st_ack);

        // master must still hold its request when ack arrives
        ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                bus.ack |-> (bus.cyc && bus.stb))
                else $error("wb_ram_slave: ack without cyc and stb");

        // every ack follows the RAM access that it answers
        ack_after_access: assert property (@(posedge clk) disable iff (!rst_n)
                bus.ack |-> (bus.we ? $past(ram_we) : $past(ram_re, 2)))
                else $error("wb_ram_slave: ack without the matching RAM access");

endmodule

/* logic/sram_subsystem.sv */
// memory subsystem top with two Wishbone classic master ports, arbiter, slave and RAM
`timescale 1ns/100ps

module sram_subsystem
        import sram_pkg::*;
#(
        parameter int addr_width = 10
) (
        input  logic                  clk,
        input  logic                  rst_n,

        // instruction port
        input  logic                  m0_cyc,
        input  logic                  m0_stb,
        input  logic                  m0_we,
        input  logic [addr_width-1:0] m0_adr,
        input  logic [lane_count-1:0] m0_sel,
        input  logic [data_width-1:0] m0_dat_w,
        output logic [data_width-1:0] m0_dat_r,
        output logic                  m0_ack,

        // data port
        input  logic                  m1_cyc,
        input  logic                  m1_stb,
        input  logic                  m1_we,
        input  logic [addr_width-1:0] m1_adr,
        input  logic [lane_count-1:0] m1_sel,
        input  logic [data_width-1:0] m1_dat_w,
        output logic [data_width-1:0] m1_dat_r,
        output logic                  m1_ack
);

        logic                  ram_re;
        logic                  ram_we;
        logic [addr_width-1:0] ram_addr;
        logic [data_width-1:0] ram_data;
        logic [data_width-1:0] ram_q;

        wb_bus_if #(.addr_width(addr_width)) u_bus ();

        wb_arbiter #(
                .addr_width (addr_width)
        ) u_arbiter (
                .clk      (clk),
                .rst_n    (rst_n),
                .m0_cyc   (m0_cyc),
                .m0_stb   (m0_stb),
                .m0_we    (m0_we),
                .m0_adr   (m0_adr),
                .m0_sel   (m0_sel),
                .m0_dat_w (m0_dat_w),
                .m0_dat_r (m0_dat_r),
                .m0_ack   (m0_ack),
                .m1_cyc   (m1_cyc),
                .m1_stb   (m1_stb),
                .m1_we    (m1_we),
                .m1_adr   (m1_adr),
                .m1_sel   (m1_sel),
                .m1_dat_w (m1_dat_w),
                .m1_dat_r (m1_dat_r),
                .m1_ack   (m1_ack),
                .shared   (u_bus.master)
        );

        wb_ram_slave #(
                .addr_width (addr_width)
        ) u_ram_slave (
                .clk      (clk),
                .rst_n    (rst_n),
                .q        (ram_q),
                .bus      (u_bus.slave),
                .ram_re   (ram_re),
                .ram_we   (ram_we),
                .ram_addr (ram_addr),
                .ram_data (ram_data)
        );

        generic_spram #(
                .addr_width (addr_width)
        ) u_spram (
                .clk  (clk),
                .re   (ram_re),
                .we   (ram_we),
                .addr (ram_addr),
                .data (ram_data),
                .q    (ram_q)
        );

endmodule

/* sim/tb_sram_subsystem.sv */
// testbench for sram_subsystem with clock, reset, two master drivers, reference model, checks
`timescale 1ns/100ps

module tb_sram_subsystem
        import sram_pkg::*;
();

        localparam int addr_width  = 10;
        localparam int ack_timeout = 64;        // cycles per transfer
        localparam int rand_window = 32;        // words used by random traffic
        localparam int rand_per_master = 200;

        logic                  clk;
        logic                  rst_n;
        logic                  m0_cyc;
        logic                  m0_stb;
        logic                  m0_we;
        logic [addr_width-1:0] m0_adr;
        logic [lane_count-1:0] m0_sel;
        logic [data_width-1:0] m0_dat_w;
        logic [data_width-1:0] m0_dat_r;
        logic                  m0_ack;
        logic                  m1_cyc;
        logic                  m1_stb;
        logic                  m1_we;
        logic [addr_width-1:0] m1_adr;
        logic [lane_count-1:0] m1_sel;
        logic [data_width-1:0] m1_dat_w;
        logic [data_width-1:0] m1_dat_r;
        logic                  m1_ack;

        logic [data_width-1:0] model [1 << addr_width];        // reference memory
        logic [data_width-1:0] m0_exp;
        logic [data_width-1:0] m1_exp;

        int   err_count = 0;
        int   timeout_count = 0;
        int   errs_at_test_start = 0;
        logic rr_check = 1'b0;          // alternation check armed
        int   rr_acks;
        logic prev_ack;                 // master of the most recent ack, 1 is m1

        sram_subsystem #(
                .addr_width (addr_width)
        ) u_sram_subsystem (
                .clk      (clk),
                .rst_n    (rst_n),
                .m0_cyc   (m0_cyc),
                .m0_stb   (m0_stb),
                .m0_we    (m0_we),
                .m0_adr   (m0_adr),
                .m0_sel   (m0_sel),
                .m0_dat_w (m0_dat_w),
                .m0_dat_r (m0_dat_r),
                .m0_ack   (m0_ack),
                .m1_cyc   (m1_cyc),
                .m1_stb   (m1_stb),
                .m1_we    (m1_we),
                .m1_adr   (m1_adr),
                .m1_sel   (m1_sel),
                .m1_dat_w (m1_dat_w),
                .m1_dat_r (m1_dat_r),
                .m1_ack   (m1_ack)
        );

        always #5 clk = ~clk;

        // selected lanes of the new word replace those of the old one
        function automatic logic [data_width-1:0] merge_lanes(
                input logic [data_width-1:0] old_word,
                input logic [data_width-1:0] new_word,
                input logic [lane_count-1:0] sel);
                ram_word_t merged;
                ram_word_t incoming;
                merged   = old_word;
                incoming = new_word;
                for (int i = 0; i < lane_count; i++) begin
                        if (sel[i]) begin
                                merged.lanes[i] = incoming.lanes[i];
                        end
                end
                return merged.word;
        endfunction

        function automatic logic [data_width-1:0] fill_word(input int unsigned a);
                return (a * 32'h9e37_79b9) ^ (a << 20) ^ 32'h5a5a_0f0f;
        endfunction

        // model follows the ack order of the two masters
        always @(posedge clk) begin
                if (rst_n && m0_ack && m0_we) begin
                        model[m0_adr] <= merge_lanes(model[m0_adr], m0_dat_w, m0_sel);
                end
                if (rst_n && m1_ack && m1_we) begin
                        model[m1_adr] <= merge_lanes(model[m1_adr], m1_dat_w, m1_sel);
                end
        end

        always @(posedge clk) begin
                if (m0_ack || m1_ack) begin
                        prev_ack <= m1_ack;
                end
                if (!rr_check) begin
                        rr_acks <= 0;
                end else if (m0_ack || m1_ack) begin
                        rr_acks <= rr_acks + 1;
                end
        end

        assign m0_exp = model[m0_adr];
        assign m1_exp = model[m1_adr];

        m0_read_data: assert property (@(posedge clk) disable iff (!rst_n)
                (m0_ack && !m0_we) |-> (m0_dat_r == m0_exp))
                else begin
                        err_count++;
                        $display("MISMATCH at %0t: m0_dat_r expected %h, actual %h",
                                 $time, $sampled(m0_exp), $sampled(m0_dat_r));
                end

        m1_read_data: assert property (@(posedge clk) disable iff (!rst_n)
                (m1_ack && !m1_we) |-> (m1_dat_r == m1_exp))
                else begin
                        err_count++;
                        $display("MISMATCH at %0t: m1_dat_r expected %h, actual %h",
                                 $time, $sampled(m1_exp), $sampled(m1_dat_r));
                end

        m0_ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
                m0_ack |-> (m0_cyc && m0_stb))
                else begin
                        err_count++;
                        $display("m0_ack went high at %0t with no m0 request pending", $time);
                end

        m1_ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
                m1_ack |-> (m1_cyc && m1_stb))
                else begin
                        err_count++;
                        $display("m1_ack went high at %0t with no m1 request pending", $time);
                end

        ack_one_master: assert property (@(posedge clk) disable iff (!rst_n)
                !(m0_ack && m1_ack))
                else begin
                        err_count++;
                        $display("both masters got ack at %0t", $time);
                end

        // with both masters pending every ack goes to the other master
        rr_alternate: assert property (@(posedge clk) disable iff (!rst_n)
                (rr_check && rr_acks > 0 && (m0_ack || m1_ack)) |-> (m1_ack != prev_ack))
                else begin
                        err_count++;
                        $display("same master got two acks in a row at %0t", $time);
                end

        task automatic instr_port_xfer(input logic we, input logic [addr_width-1:0] adr,
                                       input logic [lane_count-1:0] sel,
                                       input logic [data_width-1:0] dat);
                int   waited;
                logic seen;
                @(negedge clk);
                m0_cyc   = 1'b1;
                m0_stb   = 1'b1;
                m0_we    = we;
                m0_adr   = adr;
                m0_sel   = sel;
                m0_dat_w = dat;
                waited   = 0;
                seen     = 1'b0;
                while (!seen && waited < ack_timeout) begin
                        @(negedge clk);
                        if (m0_ack) seen = 1'b1;        // completes at the next rising edge
                        else waited++;
                end
                if (seen) begin
                        @(negedge clk);
                end else begin
                        err_count++;
                        timeout_count++;
                        $display("m0 transfer to address %h got no ack within %0d cycles",
                                 adr, ack_timeout);
                end
                m0_cyc = 1'b0;
                m0_stb = 1'b0;
                m0_we  = 1'b0;
        endtask

        task automatic data_port_xfer(input logic we, input logic [addr_width-1:0] adr,
                                      input logic [lane_count-1:0] sel,
                                      input logic [data_width-1:0] dat);
                int   waited;
                logic seen;
                @(negedge clk);
                m1_cyc   = 1'b1;
                m1_stb   = 1'b1;
                m1_we    = we;
                m1_adr   = adr;
                m1_sel   = sel;
                m1_dat_w = dat;
                waited   = 0;
                seen     = 1'b0;
                while (!seen && waited < ack_timeout) begin
                        @(negedge clk);
                        if (m1_ack) seen = 1'b1;
                        else waited++;
                end
                if (seen) begin
                        @(negedge clk);
                end else begin
                        err_count++;
                        timeout_count++;
                        $display("m1 transfer to address %h got no ack within %0d cycles",
                                 adr, ack_timeout);
                end
                m1_cyc = 1'b0;
                m1_stb = 1'b0;
                m1_we  = 1'b0;
        endtask

        task automatic report_test(input string name);
                $display("test %0s: %0s, %0d new errors", name,
                         (err_count == errs_at_test_start) ? "ok" : "failed",
                         err_count - errs_at_test_start);
                errs_at_test_start = err_count;
        endtask

        initial begin
                logic [lane_count-1:0] sel_list [10];
                logic [addr_width-1:0] a;
                void'($urandom(32'h479f2f94));
                sel_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
                             4'b0101, 4'b0110, 4'b1001, 4'b1010, 4'b1100};
                clk      = 1'b0;
                rst_n    = 1'b0;
                m0_cyc   = 1'b0;
                m0_stb   = 1'b0;
                m0_we    = 1'b0;
                m0_adr   = '0;
                m0_sel   = '0;
                m0_dat_w = '0;
                m1_cyc   = 1'b0;
                m1_stb   = 1'b0;
                m1_we    = 1'b0;
                m1_adr   = '0;
                m1_sel   = '0;
                m1_dat_w = '0;
                repeat (10) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                repeat (20) @(negedge clk);     // no requests, acks must stay low
                report_test("idle after reset");

                for (int i = 0; i < 8; i++) begin
                        instr_port_xfer(1'b1, i * 37 + 3, 4'hf, $urandom);
                end
                for (int i = 0; i < 8; i++) begin
                        instr_port_xfer(1'b0, i * 37 + 3, 4'hf, '0);
                end
                for (int i = 0; i < 8; i++) begin
                        data_port_xfer(1'b0, i * 37 + 3, 4'hf, '0);
                end
                report_test("full-word writes");

                for (int k = 0; k < 10; k++) begin
                        a = 100 + k;
                        data_port_xfer(1'b1, a, 4'hf, 32'h1122_3344);
                        data_port_xfer(1'b1, a, sel_list[k], 32'hcafe_f00d ^ k);
                        instr_port_xfer(1'b0, a, 4'hf, '0);
                end
                report_test("partial writes");

                rr_check = 1'b1;
                fork
                        for (int i = 0; i < 8; i++) begin
                                instr_port_xfer(1'b0, i * 37 + 3, 4'hf, '0);
                        end
                        for (int j = 0; j < 8; j++) begin
                                data_port_xfer(1'b1, 200 + j, 4'hf, fill_word(200 + j));
                        end
                join
                if (rr_acks != 16) begin
                        err_count++;
                        $display("round-robin run saw %0d acks instead of 16", rr_acks);
                end
                rr_check = 1'b0;
                report_test("round-robin");

                for (int w = 0; w < rand_window; w++) begin
                        data_port_xfer(1'b1, w, 4'hf, fill_word(w));    // known contents first
                end
                fork
                        for (int n = 0; n < rand_per_master; n++) begin
                                instr_port_xfer($urandom_range(0, 1),
                                                $urandom_range(0, rand_window - 1),
                                                $urandom_range(1, 15), $urandom);
                        end
                        for (int n = 0; n < rand_per_master; n++) begin
                                data_port_xfer($urandom_range(0, 1),
                                               $urandom_range(0, rand_window - 1),
                                               $urandom_range(1, 15), $urandom);
                        end
                join
                report_test("random traffic");

                repeat (2) @(negedge clk);
                $display("error count %0d, of which %0d timeouts", err_count, timeout_count);
                if (err_count == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* filelist.f */
logic/sram_pkg.sv
logic/wb_bus_if.sv
logic/generic_spram.sv
logic/wb_arbiter.sv
logic/wb_ram_slave.sv
logic/sram_subsystem.sv
sim/tb_sram_subsystem.sv
